// ==== rtl/video_pkg.sv ====
package video_pkg;

	// bits per colour channel delivered by the core
	// anything from 1 to 6 is accepted, narrower values get MSB replicated
	localparam int color_depth = 4;

	// bits per colour channel at the VGA connector
	localparam int vga_depth = 6;

	// horizontal pixel counters and line buffer address
	// 9 bits covers lines of up to 512 native pixels
	localparam int sd_hcnt_width = 9;

	// scanlines input encoding
	// darkening is only applied to the repeated copy of a line
	localparam logic [1:0] scan_none = 2'b00;

	// keep three quarters of the level
	localparam logic [1:0] scan_25 = 2'b01;

	// keep half of the level
	localparam logic [1:0] scan_50 = 2'b10;

	// keep a quarter of the level
	localparam logic [1:0] scan_75 = 2'b11;

endpackage

// ==== rtl/pixel_sampler.sv ====
module pixel_sampler (
	input  logic                              clk_sys,
	input  logic                              rst,
	input  logic                              ce_divider,
	input  logic [video_pkg::color_depth-1:0] r_in,
	input  logic [video_pkg::color_depth-1:0] g_in,
	input  logic [video_pkg::color_depth-1:0] b_in,
	input  logic                              hs_in,
	input  logic                              vs_in,
	output logic                              ce_pix,
	output logic                              ce_dbl,
	output logic [video_pkg::vga_depth-1:0]   pix_r,
	output logic [video_pkg::vga_depth-1:0]   pix_g,
	output logic [video_pkg::vga_depth-1:0]   pix_b,
	output logic                              pix_hs,
	output logic                              pix_vs
);
	import video_pkg::*;

	// free running phase of the pixel clock enables
	logic [1:0] ce_cnt;

	// widen a channel by repeating its own bits from the MSB down
	// 4 bits gives {v, v[3:2]}, 1 bit gives six copies
	function automatic logic [vga_depth-1:0] expand(input logic [color_depth-1:0] v);
		logic [vga_depth-1:0] e;
		for (int i = 0; i < vga_depth; i++) begin
			e[vga_depth-1-i] = v[color_depth-1-(i % color_depth)];
		end
		return e;
	endfunction

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			ce_cnt <= 2'd0;
		end else begin
			ce_cnt <= ce_cnt + 2'd1;
		end
	end

	// divider 0: native pixel every 4 clocks, doubled pixel every 2
	// divider 1: native pixel every 2 clocks, doubled pixel every clock
	assign ce_pix = ce_divider ? ce_cnt[0] : (ce_cnt == 2'd3);
	assign ce_dbl = ce_divider ? 1'b1 : ce_cnt[0];

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			pix_r  <= '0;
			pix_g  <= '0;
			pix_b  <= '0;
			pix_hs <= 1'b0;
			pix_vs <= 1'b0;
		end else if (ce_pix) begin
			pix_r  <= expand(r_in);
			pix_g  <= expand(g_in);
			pix_b  <= expand(b_in);
			pix_hs <= hs_in;
			pix_vs <= vs_in;
		end
	end

endmodule

// ==== rtl/line_buffer.sv ====
module line_buffer (
	input  logic                                clk_sys,

	// write port, filled with the line currently arriving
	input  logic                                wr_en,
	input  logic                                wr_bank,
	input  logic [video_pkg::sd_hcnt_width-1:0] wr_addr,
	input  logic [3*video_pkg::vga_depth-1:0]   wr_data,

	// read port, replays the previous line
	input  logic                                rd_bank,
	input  logic [video_pkg::sd_hcnt_width-1:0] rd_addr,
	output logic [3*video_pkg::vga_depth-1:0]   rd_data
);
	import video_pkg::*;

	// two banks, bank select is the top address bit
	logic [3*vga_depth-1:0] mem [0:2*(2**sd_hcnt_width)-1];

	// pixel layout is {r, g, b}, each vga_depth wide
	always_ff @(posedge clk_sys) begin
		if (wr_en) begin
			mem[{wr_bank, wr_addr}] <= wr_data;
		end
	end

	// registered read, data appears one clock after the address
	always_ff @(posedge clk_sys) begin
		rd_data <= mem[{rd_bank, rd_addr}];
	end

endmodule

// ==== rtl/scandoubler.sv ====
module scandoubler (
	input  logic                                clk_sys,
	input  logic                                rst,
	input  logic                                ce_pix,
	input  logic                                ce_dbl,
	input  logic [video_pkg::vga_depth-1:0]     pix_r,
	input  logic [video_pkg::vga_depth-1:0]     pix_g,
	input  logic [video_pkg::vga_depth-1:0]     pix_b,
	input  logic                                pix_hs,
	input  logic                                pix_vs,
	input  logic [3*video_pkg::vga_depth-1:0]   rd_data,
	output logic                                wr_en,
	output logic                                wr_bank,
	output logic [video_pkg::sd_hcnt_width-1:0] wr_addr,
	output logic [3*video_pkg::vga_depth-1:0]   wr_data,
	output logic                                rd_bank,
	output logic [video_pkg::sd_hcnt_width-1:0] rd_addr,
	output logic [video_pkg::vga_depth-1:0]     sd_r,
	output logic [video_pkg::vga_depth-1:0]     sd_g,
	output logic [video_pkg::vga_depth-1:0]     sd_b,
	output logic                                sd_hs,
	output logic                                sd_vs,
	output logic                                sd_repeat
);
	import video_pkg::*;

	logic                     hs_q;
	logic                     hs_rise;
	logic                     restart_pend;
	logic                     line_start;
	logic [sd_hcnt_width-1:0] in_col;
	logic [sd_hcnt_width-1:0] line_len;
	logic [sd_hcnt_width-1:0] hs_len;
	logic [sd_hcnt_width-1:0] out_col;
	logic                     bank;
	logic                     seen_line;
	logic                     line_ok;
	logic                     repeat_line;
	logic                     vs_line;
	logic                     vs_out;
	logic                     s1_hs;
	logic                     s1_vs;
	logic                     s1_rep;
	logic                     s1_ok;

	// pix_hs only moves on ce_pix, so the rise lasts a single clock
	assign hs_rise = pix_hs & ~hs_q;

	// the new line starts on the next ce_dbl so every doubled pixel
	// has the same width, this always lands before the next ce_pix
	assign line_start = ce_dbl & (hs_rise | restart_pend);

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			hs_q         <= 1'b0;
			restart_pend <= 1'b0;
		end else begin
			hs_q         <= pix_hs;
			restart_pend <= (hs_rise | restart_pend) & ~ce_dbl;
		end
	end

	// input side: count native pixels and swap banks per line
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			in_col    <= '0;
			line_len  <= '0;
			bank      <= 1'b0;
			seen_line <= 1'b0;
			line_ok   <= 1'b0;
			vs_line   <= 1'b0;
			vs_out    <= 1'b0;
		end else if (line_start) begin
			in_col    <= '0;
			line_len  <= in_col;
			bank      <= ~bank;
			seen_line <= 1'b1;
			// first line after reset is partial, wait for a full one
			line_ok   <= seen_line;
			vs_line   <= pix_vs;
			vs_out    <= vs_line;
		end else if (ce_pix) begin
			in_col <= in_col + 1'b1;
		end
	end

	assign wr_en   = ce_pix;
	assign wr_bank = bank;
	assign wr_addr = in_col;
	assign wr_data = {pix_r, pix_g, pix_b};

	// previous line lives in the other bank
	assign rd_bank = ~bank;
	assign rd_addr = out_col;

	// output side: two passes over the stored line per input line
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			out_col     <= '0;
			repeat_line <= 1'b0;
		end else if (line_start) begin
			out_col     <= '0;
			repeat_line <= 1'b0;
		end else if (ce_dbl) begin
			if (out_col == line_len - 1'b1) begin
				out_col     <= '0;
				repeat_line <= ~repeat_line;
			end else begin
				out_col <= out_col + 1'b1;
			end
		end
	end

	// doubled hsync covers a quarter of each half line
	assign hs_len = line_len >> 2;

	// stage 1 lines up with the RAM read, stage 2 drives the outputs
	always_ff @(posedge clk_sys) begin
		if (rst) begin
			s1_hs     <= 1'b0;
			s1_vs     <= 1'b0;
			s1_rep    <= 1'b0;
			s1_ok     <= 1'b0;
			sd_hs     <= 1'b0;
			sd_vs     <= 1'b0;
			sd_repeat <= 1'b0;
			sd_r      <= '0;
			sd_g      <= '0;
			sd_b      <= '0;
		end else begin
			s1_hs     <= line_ok & (out_col < hs_len);
			s1_vs     <= vs_out;
			s1_rep    <= repeat_line;
			s1_ok     <= line_ok;
			sd_hs     <= s1_hs;
			sd_vs     <= s1_vs;
			sd_repeat <= s1_rep;
			if (s1_ok) begin
				{sd_r, sd_g, sd_b} <= rd_data;
			end else begin
				sd_r <= '0;
				sd_g <= '0;
				sd_b <= '0;
			end
		end
	end

endmodule

// ==== rtl/video_out_stage.sv ====
module video_out_stage (
	input  logic                            clk_sys,
	input  logic                            rst,
	input  logic [1:0]                      scanlines,
	input  logic                            scandoubler_disable,
	input  logic [video_pkg::vga_depth-1:0] pix_r,
	input  logic [video_pkg::vga_depth-1:0] pix_g,
	input  logic [video_pkg::vga_depth-1:0] pix_b,
	input  logic                            pix_hs,
	input  logic                            pix_vs,
	input  logic [video_pkg::vga_depth-1:0] sd_r,
	input  logic [video_pkg::vga_depth-1:0] sd_g,
	input  logic [video_pkg::vga_depth-1:0] sd_b,
	input  logic                            sd_hs,
	input  logic                            sd_vs,
	input  logic                            sd_repeat,
	output logic [video_pkg::vga_depth-1:0] vga_r,
	output logic [video_pkg::vga_depth-1:0] vga_g,
	output logic [video_pkg::vga_depth-1:0] vga_b,
	output logic                            vga_hs,
	output logic                            vga_vs
);
	import video_pkg::*;

	logic [vga_depth-1:0] dim_r;
	logic [vga_depth-1:0] dim_g;
	logic [vga_depth-1:0] dim_b;

	// scanline darkening of one channel
	function automatic logic [vga_depth-1:0] shade(input logic [vga_depth-1:0] v,
			input logic [1:0] level);
		logic [vga_depth-1:0] s;
		case (level)
			scan_none: s = v;
			scan_25:   s = v - (v >> 2);
			scan_50:   s = v >> 1;
			scan_75:   s = v >> 2;
			default:   s = v;
		endcase
		return s;
	endfunction

	// only the second copy of a doubled line is darkened
	assign dim_r = sd_repeat ? shade(sd_r, scanlines) : sd_r;
	assign dim_g = sd_repeat ? shade(sd_g, scanlines) : sd_g;
	assign dim_b = sd_repeat ? shade(sd_b, scanlines) : sd_b;

	always_ff @(posedge clk_sys) begin
		if (rst) begin
			vga_r  <= '0;
			vga_g  <= '0;
			vga_b  <= '0;
			vga_hs <= 1'b0;
			vga_vs <= 1'b0;
		end else if (scandoubler_disable) begin
			// 15 kHz passthrough
			vga_r  <= pix_r;
			vga_g  <= pix_g;
			vga_b  <= pix_b;
			vga_hs <= pix_hs;
			vga_vs <= pix_vs;
		end else begin
			vga_r  <= dim_r;
			vga_g  <= dim_g;
			vga_b  <= dim_b;
			vga_hs <= sd_hs;
			vga_vs <= sd_vs;
		end
	end

endmodule

// ==== rtl/video.sv ====
module video (
	input  logic                              clk_sys,
	input  logic                              rst,
	input  logic [1:0]                        scanlines,
	input  logic                              ce_divider,
	input  logic                              scandoubler_disable,
	input  logic [video_pkg::color_depth-1:0] R,
	input  logic [video_pkg::color_depth-1:0] G,
	input  logic [video_pkg::color_depth-1:0] B,
	input  logic                              HSync,
	input  logic                              VSync,
	output logic [video_pkg::vga_depth-1:0]   VGA_R,
	output logic [video_pkg::vga_depth-1:0]   VGA_G,
	output logic [video_pkg::vga_depth-1:0]   VGA_B,
	output logic                              VGA_HS,
	output logic                              VGA_VS
);
	import video_pkg::*;

	logic                     ce_pix;
	logic                     ce_dbl;
	logic [vga_depth-1:0]     pix_r;
	logic [vga_depth-1:0]     pix_g;
	logic [vga_depth-1:0]     pix_b;
	logic                     pix_hs;
	logic                     pix_vs;

	// line buffer ports
	logic                     wr_en;
	logic                     wr_bank;
	logic [sd_hcnt_width-1:0] wr_addr;
	logic [3*vga_depth-1:0]   wr_data;
	logic                     rd_bank;
	logic [sd_hcnt_width-1:0] rd_addr;
	logic [3*vga_depth-1:0]   rd_data;

	// doubled path into the output stage
	logic [vga_depth-1:0]     sd_r;
	logic [vga_depth-1:0]     sd_g;
	logic [vga_depth-1:0]     sd_b;
	logic                     sd_hs;
	logic                     sd_vs;
	logic                     sd_repeat;

	pixel_sampler sampler (
		.clk_sys    (clk_sys),
		.rst        (rst),
		.ce_divider (ce_divider),
		.r_in       (R),
		.g_in       (G),
		.b_in       (B),
		.hs_in      (HSync),
		.vs_in      (VSync),
		.ce_pix     (ce_pix),
		.ce_dbl     (ce_dbl),
		.pix_r      (pix_r),
		.pix_g      (pix_g),
		.pix_b      (pix_b),
		.pix_hs     (pix_hs),
		.pix_vs     (pix_vs)
	);

	scandoubler doubler (
		.clk_sys   (clk_sys),
		.rst       (rst),
		.ce_pix    (ce_pix),
		.ce_dbl    (ce_dbl),
		.pix_r     (pix_r),
		.pix_g     (pix_g),
		.pix_b     (pix_b),
		.pix_hs    (pix_hs),
		.pix_vs    (pix_vs),
		.rd_data   (rd_data),
		.wr_en     (wr_en),
		.wr_bank   (wr_bank),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data),
		.rd_bank   (rd_bank),
		.rd_addr   (rd_addr),
		.sd_r      (sd_r),
		.sd_g      (sd_g),
		.sd_b      (sd_b),
		.sd_hs     (sd_hs),
		.sd_vs     (sd_vs),
		.sd_repeat (sd_repeat)
	);

	line_buffer linebuf (
		.clk_sys (clk_sys),
		.wr_en   (wr_en),
		.wr_bank (wr_bank),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_bank (rd_bank),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	video_out_stage out_stage (
		.clk_sys             (clk_sys),
		.rst                 (rst),
		.scanlines           (scanlines),
		.scandoubler_disable (scandoubler_disable),
		.pix_r               (pix_r),
		.pix_g               (pix_g),
		.pix_b               (pix_b),
		.pix_hs              (pix_hs),
		.pix_vs              (pix_vs),
		.sd_r                (sd_r),
		.sd_g                (sd_g),
		.sd_b                (sd_b),
		.sd_hs               (sd_hs),
		.sd_vs               (sd_vs),
		.sd_repeat           (sd_repeat),
		.vga_r               (VGA_R),
		.vga_g               (VGA_G),
		.vga_b               (VGA_B),
		.vga_hs              (VGA_HS),
		.vga_vs              (VGA_VS)
	);

endmodule

// ==== test/video_tb.sv ====
module video_tb;
	import video_pkg::*;

	localparam int line_pix = 64;
	localparam int hs_pix = 8;
	localparam int frame_lines = 8;
	localparam int vs_lines = 1;
	localparam int phase_frames = 2;
	localparam int phase_count = 7;
	// slowest raster is 4 clocks per native pixel
	localparam int frame_clks = line_pix * frame_lines * 4;
	localparam int cycle_limit = phase_count * 3 * frame_clks + 1000;

	logic                   clk_sys = 1'b0;
	logic                   rst = 1'b1;
	logic [1:0]             scanlines = scan_none;
	logic                   ce_divider = 1'b0;
	logic                   scandoubler_disable = 1'b1;
	logic [color_depth-1:0] R = '0;
	logic [color_depth-1:0] G = '0;
	logic [color_depth-1:0] B = '0;
	logic                   HSync = 1'b0;
	logic                   VSync = 1'b0;
	logic [vga_depth-1:0]   VGA_R;
	logic [vga_depth-1:0]   VGA_G;
	logic [vga_depth-1:0]   VGA_B;
	logic                   VGA_HS;
	logic                   VGA_VS;

	// pixel enable model and line bookkeeping
	logic [1:0]           ce_phase = 2'd0;
	logic                 ce_now;
	logic [15:0]          lfsr_state;
	logic                 native_on = 1'b0;
	logic                 dbl_on = 1'b0;
	int                   lines_started = 0;
	int                   line_in_frame = 0;
	logic [vga_depth-1:0] fill_r [line_pix];
	logic [vga_depth-1:0] fill_g [line_pix];
	logic [vga_depth-1:0] fill_b [line_pix];
	logic [vga_depth-1:0] done_r [line_pix];
	logic [vga_depth-1:0] done_g [line_pix];
	logic [vga_depth-1:0] done_b [line_pix];

	// native path model, sample register then output register
	logic [vga_depth-1:0] m_pix_r;
	logic [vga_depth-1:0] m_pix_g;
	logic [vga_depth-1:0] m_pix_b;
	logic                 m_pix_hs;
	logic                 m_pix_vs;
	logic [vga_depth-1:0] m_vga_r;
	logic [vga_depth-1:0] m_vga_g;
	logic [vga_depth-1:0] m_vga_b;
	logic                 m_vga_hs;
	logic                 m_vga_vs;

	// doubled path checker state
	logic                 rst_d = 1'b0;
	logic                 hs_d = 1'b0;
	logic                 vs_d = 1'b0;
	logic                 have_line = 1'b0;
	logic                 in_copy = 1'b0;
	logic                 copy_rep = 1'b0;
	int                   since_rise = 0;
	int                   last_line_seen = 0;
	int                   rises_this_line = 0;
	logic [vga_depth-1:0] cap_r [line_pix];
	logic [vga_depth-1:0] cap_g [line_pix];
	logic [vga_depth-1:0] cap_b [line_pix];
	int                   native_checks = 0;
	int                   pix_checks = 0;
	int                   vs_rises = 0;
	int                   cycles = 0;

	video uut (
		.clk_sys             (clk_sys),
		.rst                 (rst),
		.scanlines           (scanlines),
		.ce_divider          (ce_divider),
		.scandoubler_disable (scandoubler_disable),
		.R                   (R),
		.G                   (G),
		.B                   (B),
		.HSync               (HSync),
		.VSync               (VSync),
		.VGA_R               (VGA_R),
		.VGA_G               (VGA_G),
		.VGA_B               (VGA_B),
		.VGA_HS              (VGA_HS),
		.VGA_VS              (VGA_VS)
	);

	always #2 clk_sys = ~clk_sys;

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, expected, actual);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// one LFSR step per bit taken
	task automatic take_bits(output logic [color_depth-1:0] v);
		v = '0;
		for (int i = 0; i < color_depth; i++) begin
			v[i] = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// append copies of the value until 6 bits are filled, keep the top 6
	function automatic logic [vga_depth-1:0] expand_ref(input logic [color_depth-1:0] v);
		logic [11:0] acc;
		int          filled;
		acc = '0;
		filled = 0;
		while (filled < vga_depth) begin
			acc = (acc << color_depth) | 12'(v);
			filled += color_depth;
		end
		return acc[filled-1 -: vga_depth];
	endfunction

	function automatic logic [vga_depth-1:0] shade_ref(input logic [vga_depth-1:0] v,
			input logic [1:0] level);
		case (level)
			scan_25: return v - v / 6'd4;
			scan_50: return v / 6'd2;
			scan_75: return v / 6'd4;
			default: return v;
		endcase
	endfunction

	always @(posedge clk_sys) begin
		if (rst) begin
			ce_phase <= 2'd0;
		end else begin
			ce_phase <= ce_phase + 2'd1;
		end
	end

	// every 4 clocks, or every 2 with the divider set
	assign ce_now = ce_divider ? ce_phase[0] : (ce_phase == 2'd3);

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit) begin
			$display("simulation ran past its cycle limit without finishing");
			$display("TEST FAILED");
			$fatal(1);
		end
	end

	always @(posedge clk_sys) begin
		rst_d <= rst;
		if (rst_d) begin
			assert (VGA_R == 6'd0) else report_mismatch("VGA_R", 0, int'(VGA_R));
			assert (VGA_G == 6'd0) else report_mismatch("VGA_G", 0, int'(VGA_G));
			assert (VGA_B == 6'd0) else report_mismatch("VGA_B", 0, int'(VGA_B));
			assert (VGA_HS == 1'b0) else report_mismatch("VGA_HS", 0, int'(VGA_HS));
			assert (VGA_VS == 1'b0) else report_mismatch("VGA_VS", 0, int'(VGA_VS));
		end
	end

	always @(posedge clk_sys) begin
		if (ce_now) begin
			m_pix_r  <= expand_ref(R);
			m_pix_g  <= expand_ref(G);
			m_pix_b  <= expand_ref(B);
			m_pix_hs <= HSync;
			m_pix_vs <= VSync;
		end
		m_vga_r  <= m_pix_r;
		m_vga_g  <= m_pix_g;
		m_vga_b  <= m_pix_b;
		m_vga_hs <= m_pix_hs;
		m_vga_vs <= m_pix_vs;
		if (native_on) begin
			native_checks <= native_checks + 1;
			assert (VGA_R == m_vga_r) else report_mismatch("VGA_R", int'(m_vga_r), int'(VGA_R));
			assert (VGA_G == m_vga_g) else report_mismatch("VGA_G", int'(m_vga_g), int'(VGA_G));
			assert (VGA_B == m_vga_b) else report_mismatch("VGA_B", int'(m_vga_b), int'(VGA_B));
			assert (VGA_HS == m_vga_hs)
				else report_mismatch("VGA_HS", int'(m_vga_hs), int'(VGA_HS));
			assert (VGA_VS == m_vga_vs)
				else report_mismatch("VGA_VS", int'(m_vga_vs), int'(VGA_VS));
		end
	end

	always @(posedge clk_sys) begin : doubled_check
		int                   idx;
		int                   dbl_per;
		logic                 chk;
		logic                 rep;
		logic                 new_line;
		logic [vga_depth-1:0] e_r;
		logic [vga_depth-1:0] e_g;
		logic [vga_depth-1:0] e_b;
		chk = 1'b0;
		rep = copy_rep;
		idx = 0;
		new_line = 1'b0;
		dbl_per = ce_divider ? 1 : 2;
		hs_d <= VGA_HS;
		if (!dbl_on) begin
			have_line <= 1'b0;
			in_copy <= 1'b0;
			since_rise <= 0;
			last_line_seen <= lines_started;
		end else if (VGA_HS && !hs_d) begin
			new_line = (lines_started != last_line_seen);
			if (new_line) begin
				if (have_line) begin
					assert (rises_this_line == 2)
						else report_mismatch("VGA_HS rises per line", 2, rises_this_line);
				end
				for (int i = 0; i < line_pix; i++) begin
					cap_r[i] <= done_r[i];
					cap_g[i] <= done_g[i];
					cap_b[i] <= done_b[i];
				end
				have_line <= 1'b1;
				rises_this_line <= 1;
				last_line_seen <= lines_started;
				rep = 1'b0;
			end else begin
				rises_this_line <= rises_this_line + 1;
				rep = 1'b1;
			end
			// each copy lasts half an input line
			if (in_copy) begin
				assert (since_rise == line_pix * dbl_per)
					else report_mismatch("VGA_HS spacing", line_pix * dbl_per, since_rise);
			end
			in_copy <= 1'b1;
			since_rise <= 1;
			copy_rep <= rep;
			chk = new_line | have_line;
		end else if (in_copy) begin
			// a missing rise lets the count run past half a line
			assert (since_rise < line_pix * dbl_per)
				else report_mismatch("VGA_HS spacing", line_pix * dbl_per, since_rise);
			since_rise <= since_rise + 1;
			if (since_rise % dbl_per == 0 && since_rise / dbl_per < line_pix) begin
				chk = have_line;
				idx = since_rise / dbl_per;
			end
		end
		if (chk) begin
			if (new_line) begin
				e_r = done_r[idx];
				e_g = done_g[idx];
				e_b = done_b[idx];
			end else begin
				e_r = cap_r[idx];
				e_g = cap_g[idx];
				e_b = cap_b[idx];
			end
			if (rep) begin
				e_r = shade_ref(e_r, scanlines);
				e_g = shade_ref(e_g, scanlines);
				e_b = shade_ref(e_b, scanlines);
			end
			pix_checks <= pix_checks + 1;
			assert (VGA_R == e_r) else report_mismatch("VGA_R", int'(e_r), int'(VGA_R));
			assert (VGA_G == e_g) else report_mismatch("VGA_G", int'(e_g), int'(VGA_G));
			assert (VGA_B == e_b) else report_mismatch("VGA_B", int'(e_b), int'(VGA_B));
		end
	end

	// doubled vsync shows up while the line after the vsync line arrives
	always @(posedge clk_sys) begin
		vs_d <= VGA_VS;
		if (dbl_on && VGA_VS && !vs_d) begin
			vs_rises <= vs_rises + 1;
			assert (line_in_frame == vs_lines)
				else report_mismatch("VGA_VS rise line", vs_lines, line_in_frame);
		end
	end

	task automatic wait_sample_edge();
		@(posedge clk_sys);
		while (!ce_now) begin
			@(posedge clk_sys);
		end
	endtask

	task automatic drive_line(input int lf, input logic dis, input logic en, input logic last);
		logic [color_depth-1:0] r;
		logic [color_depth-1:0] g;
		logic [color_depth-1:0] b;
		for (int p = 0; p < line_pix; p++) begin
			wait_sample_edge();
			take_bits(r);
			take_bits(g);
			take_bits(b);
			R <= r;
			G <= g;
			B <= b;
			HSync <= (p < hs_pix);
			VSync <= (lf < vs_lines);
			if (p == 0) begin
				for (int i = 0; i < line_pix; i++) begin
					done_r[i] = fill_r[i];
					done_g[i] = fill_g[i];
					done_b[i] = fill_b[i];
				end
				lines_started <= lines_started + 1;
				line_in_frame <= lf;
				native_on <= dis & en;
				dbl_on <= ~dis & en;
			end
			if (last && p == line_pix - 1) begin
				native_on <= 1'b0;
				dbl_on <= 1'b0;
			end
			fill_r[p] = expand_ref(r);
			fill_g[p] = expand_ref(g);
			fill_b[p] = expand_ref(b);
		end
	endtask

	// first two lines of a phase let the doubler settle
	task automatic run_phase(input logic div, input logic dis, input logic [1:0] scan);
		int k;
		wait_sample_edge();
		ce_divider <= div;
		scandoubler_disable <= dis;
		scanlines <= scan;
		for (int f = 0; f < phase_frames; f++) begin
			for (int l = 0; l < frame_lines; l++) begin
				k = f * frame_lines + l;
				drive_line(l, dis, k >= 2, k == phase_frames * frame_lines - 1);
			end
		end
	endtask

	initial begin
		lfsr_state = 16'd18262;
		repeat (10) @(posedge clk_sys);
		rst <= 1'b0;
		run_phase(1'b0, 1'b1, scan_none);
		run_phase(1'b1, 1'b1, scan_none);
		run_phase(1'b0, 1'b0, scan_none);
		run_phase(1'b1, 1'b0, scan_none);
		run_phase(1'b0, 1'b0, scan_25);
		run_phase(1'b1, 1'b0, scan_50);
		run_phase(1'b0, 1'b0, scan_75);
		repeat (4) @(posedge clk_sys);
		// native, doubled and vsync checks must all have fired
		if (native_checks > 0 && pix_checks > 0 && vs_rises > 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			$display("native or doubled checks were never reached");
			$display("TEST FAILED");
			$fatal(1);
		end
	end

endmodule

// ==== compile.f ====
rtl/video_pkg.sv
rtl/pixel_sampler.sv
rtl/line_buffer.sv
rtl/scandoubler.sv
rtl/video_out_stage.sv
rtl/video.sv
test/video_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module video_tb -o Vvideo_tb \
	&& ./obj_dir/Vvideo_tb | tee /dev/stderr | grep -q "^TEST OK$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
